//--- hdl/lwc_controller.sv
// Command sequencer only; data words reach the cipher inside commands, cipher_done must be a pulse
`timescale 1ns/1ps
`default_nettype none

module lwc_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  lwc_pkg::word_t       pdi_data,
    input  logic                 pdi_valid,
    output logic                 pdi_ready,
    input  lwc_pkg::word_t       sdi_data,
    input  logic                 sdi_valid,
    output logic                 sdi_ready,
    input  logic                 cipher_inst_ready,
    input  logic                 cipher_done,
    output lwc_pkg::cipher_cmd_t cipher_cmd_out,
    output logic                 cipher_cmd_valid,
    input  logic                 cipher_cmd_ready,
    output lwc_pkg::do_cmd_t     do_cmd_out,
    output logic                 do_cmd_valid,
    input  logic                 do_cmd_ready
);

    lwc_pkg::src_t        src;
    logic                 take;
    lwc_pkg::in_beat_t    beat;
    logic                 beat_valid;
    logic                 load;
    logic                 step;
    logic                 is_empty;
    logic                 is_last_word;
    logic                 cipher_push;
    logic                 do_push;
    lwc_pkg::cipher_cmd_t cipher_cmd;
    lwc_pkg::do_cmd_t     do_cmd;
    logic                 cipher_free;
    logic                 do_free;

    lwc_input_port u_input_port (
        .clk        (clk),
        .rst        (rst),
        .pdi_data   (pdi_data),
        .sdi_data   (sdi_data),
        .pdi_valid  (pdi_valid),
        .sdi_valid  (sdi_valid),
        .pdi_ready  (pdi_ready),
        .sdi_ready  (sdi_ready),
        .src        (src),
        .take       (take),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    lwc_seg_counter u_seg_counter (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .step         (step),
        .size         (beat.size),
        .is_empty     (is_empty),
        .is_last_word (is_last_word)
    );

    lwc_sequencer u_sequencer (
        .clk               (clk),
        .rst               (rst),
        .beat              (beat),
        .beat_valid        (beat_valid),
        .src               (src),
        .take              (take),
        .load              (load),
        .step              (step),
        .is_empty          (is_empty),
        .is_last_word      (is_last_word),
        .cipher_inst_ready (cipher_inst_ready),
        .cipher_done       (cipher_done),
        .cipher_free       (cipher_free),
        .do_free           (do_free),
        .cipher_push       (cipher_push),
        .do_push           (do_push),
        .cipher_cmd        (cipher_cmd),
        .do_cmd            (do_cmd)
    );

    lwc_output_stage u_output_stage (
        .clk              (clk),
        .rst              (rst),
        .cipher_push      (cipher_push),
        .do_push          (do_push),
        .cipher_cmd       (cipher_cmd),
        .do_cmd           (do_cmd),
        .cipher_free      (cipher_free),
        .do_free          (do_free),
        .cipher_cmd_out   (cipher_cmd_out),
        .cipher_cmd_valid (cipher_cmd_valid),
        .cipher_cmd_ready (cipher_cmd_ready),
        .do_cmd_out       (do_cmd_out),
        .do_cmd_valid     (do_cmd_valid),
        .do_cmd_ready     (do_cmd_ready)
    );

endmodule

`default_nettype wire

//--- hdl/lwc_input_port.sv
// One-word holding register shared by PDI and SDI; only the source selected by src is accepted
`timescale 1ns/1ps
`default_nettype none

module lwc_input_port (
    input  logic              clk,
    input  logic              rst,
    input  lwc_pkg::word_t    pdi_data,
    input  lwc_pkg::word_t    sdi_data,
    input  logic              pdi_valid,
    input  logic              sdi_valid,
    output logic              pdi_ready,
    output logic              sdi_ready,
    input  lwc_pkg::src_t     src,
    input  logic              take,
    output lwc_pkg::in_beat_t beat,
    output logic              beat_valid
);

    logic           held;
    lwc_pkg::word_t held_word;
    logic           pdi_xfer;
    logic           sdi_xfer;

    // Ready only toward the selected source and only while empty
    assign pdi_ready = (src == lwc_pkg::PDI) && !held;
    assign sdi_ready = (src == lwc_pkg::SDI) && !held;

    assign pdi_xfer = pdi_valid && pdi_ready;
    assign sdi_xfer = sdi_valid && sdi_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held <= 1'b0;
        end else if (pdi_xfer || sdi_xfer) begin
            held <= 1'b1;
        end else if (take) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pdi_xfer) begin
            held_word <= pdi_data;
        end else if (sdi_xfer) begin
            held_word <= sdi_data;
        end
    end

    // Header fields, valid whether the word is a header or not
    assign beat.opcode = lwc_pkg::opcode_t'(
        held_word[lwc_pkg::OPCODE_MSB -: $bits(lwc_pkg::opcode_t)]);
    assign beat.eot    = held_word[lwc_pkg::EOT_BIT];
    assign beat.size   = held_word[lwc_pkg::SIZE_MSB:0];
    assign beat.data   = held_word;

    assign beat_valid = held;

endmodule

`default_nettype wire

//--- hdl/lwc_output_stage.sv
// Two one-entry command slots; a slot refills on the same edge its command is accepted
`timescale 1ns/1ps
`default_nettype none

module lwc_output_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cipher_push,
    input  logic                 do_push,
    input  lwc_pkg::cipher_cmd_t cipher_cmd,
    input  lwc_pkg::do_cmd_t     do_cmd,
    output logic                 cipher_free,
    output logic                 do_free,
    output lwc_pkg::cipher_cmd_t cipher_cmd_out,
    output logic                 cipher_cmd_valid,
    input  logic                 cipher_cmd_ready,
    output lwc_pkg::do_cmd_t     do_cmd_out,
    output logic                 do_cmd_valid,
    input  logic                 do_cmd_ready
);

    logic cipher_full;
    logic do_full;

    assign cipher_free = !cipher_full || cipher_cmd_ready;
    assign do_free     = !do_full || do_cmd_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cipher_full <= 1'b0;
            do_full     <= 1'b0;
        end else begin
            if (cipher_push) begin
                cipher_full <= 1'b1;
            end else if (cipher_cmd_ready) begin
                cipher_full <= 1'b0;
            end
            if (do_push) begin
                do_full <= 1'b1;
            end else if (do_cmd_ready) begin
                do_full <= 1'b0;
            end
        end
    end

    // Command payloads
    always_ff @(posedge clk) begin
        if (cipher_push) begin
            cipher_cmd_out <= cipher_cmd;
        end
        if (do_push) begin
            do_cmd_out <= do_cmd;
        end
    end

    assign cipher_cmd_valid = cipher_full;
    assign do_cmd_valid     = do_full;

endmodule

`default_nettype wire

//--- hdl/lwc_pkg.sv
// Fixed 32-bit LWC words with a 16-bit segment size; field positions follow the LWC API header
`default_nettype none

package lwc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] seg_size_t;

    // Instruction and segment type field
    typedef enum logic [3:0] {
        ENC    = 4'b0010,
        DEC    = 4'b0011,
        LDKEY  = 4'b0100,
        ACTKEY = 4'b0111
    } opcode_t;

    typedef enum logic [2:0] {
        KEY  = 3'd0,
        NPUB = 3'd1,
        AD   = 3'd2,
        DATA = 3'd3,
        TAG  = 3'd4
    } seg_kind_t;

    typedef enum logic [2:0] {
        MSG_HEADER = 3'b010,
        TAG_HEADER = 3'b100,
        SUCCESS    = 3'b101,
        VERIFY     = 3'b110
    } do_type_t;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        PDI  = 2'd1,
        SDI  = 2'd2
    } src_t;

    // Header word layout
    localparam int OPCODE_MSB = 31;
    localparam int EOT_BIT    = 25;
    localparam int SIZE_MSB   = 15;

    localparam seg_size_t BYTES_PER_WORD = 4;

    typedef struct packed {
        opcode_t   opcode;
        logic      eot;
        seg_size_t size;
        word_t     data;
    } in_beat_t;

    typedef struct packed {
        seg_kind_t kind;
        logic      last;
        logic      empty;
        word_t     data;
    } cipher_cmd_t;

    typedef struct packed {
        do_type_t  do_type;
        seg_size_t size;
    } do_cmd_t;

endpackage

`default_nettype wire

//--- hdl/lwc_seg_counter.sv
// Byte counter for one segment; flags come from registers and lag load or step by one cycle
`timescale 1ns/1ps
`default_nettype none

module lwc_seg_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic               step,
    input  lwc_pkg::seg_size_t size,
    output logic               is_empty,
    output logic               is_last_word
);

    lwc_pkg::seg_size_t remaining;
    logic               zero_size;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            remaining <= '0;
            zero_size <= 1'b0;
        end else if (load) begin
            remaining <= size;
            zero_size <= (size == '0);
        end else if (step) begin
            // Saturate so a short final word leaves zero
            if (remaining > lwc_pkg::BYTES_PER_WORD) begin
                remaining <= remaining - lwc_pkg::BYTES_PER_WORD;
            end else begin
                remaining <= '0;
            end
        end
    end

    assign is_empty     = zero_size;
    assign is_last_word = (remaining <= lwc_pkg::BYTES_PER_WORD);

endmodule

`default_nettype wire

//--- hdl/lwc_sequencer.sv
// Handles ACTKEY, ENC and DEC only; hash and other opcodes on PDI are dropped silently
`timescale 1ns/1ps
`default_nettype none

module lwc_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  lwc_pkg::in_beat_t    beat,
    input  logic                 beat_valid,
    output lwc_pkg::src_t        src,
    output logic                 take,
    output logic                 load,
    output logic                 step,
    input  logic                 is_empty,
    input  logic                 is_last_word,
    input  logic                 cipher_inst_ready,
    input  logic                 cipher_done,
    input  logic                 cipher_free,
    input  logic                 do_free,
    output logic                 cipher_push,
    output logic                 do_push,
    output lwc_pkg::cipher_cmd_t cipher_cmd,
    output lwc_pkg::do_cmd_t     do_cmd
);

    typedef enum logic [3:0] {
        INST,
        KEY_INST,
        HEADER,
        HEADER_DECIDE,
        DATA_WORDS,
        EMPTY_BLOCK,
        TAG_HEADER,
        WAIT_TAG,
        STATUS
    } state_t;

    state_t             state;
    state_t             state_next;
    lwc_pkg::seg_kind_t seg_kind;
    lwc_pkg::seg_kind_t seg_kind_next;
    lwc_pkg::opcode_t   inst_op;
    lwc_pkg::opcode_t   inst_op_next;
    logic               seg_eot;
    logic               seg_eot_next;
    logic               seg_done;
    lwc_pkg::src_t      src_next;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= INST;
            seg_kind <= lwc_pkg::KEY;
            inst_op  <= lwc_pkg::ENC;
            seg_eot  <= 1'b0;
            src      <= lwc_pkg::NONE;
        end else begin
            state    <= state_next;
            seg_kind <= seg_kind_next;
            inst_op  <= inst_op_next;
            seg_eot  <= seg_eot_next;
            src      <= src_next;
        end
    end

    always_comb begin
        state_next       = state;
        seg_kind_next    = seg_kind;
        inst_op_next     = inst_op;
        seg_eot_next     = seg_eot;
        seg_done         = 1'b0;
        take             = 1'b0;
        load             = 1'b0;
        step             = 1'b0;
        cipher_push      = 1'b0;
        do_push          = 1'b0;
        cipher_cmd.kind  = seg_kind;
        cipher_cmd.last  = 1'b0;
        cipher_cmd.empty = 1'b0;
        cipher_cmd.data  = beat.data;
        do_cmd.do_type   = lwc_pkg::MSG_HEADER;
        do_cmd.size      = beat.size;

        case (state)
            INST: begin
                if (beat_valid && cipher_inst_ready) begin
                    take = 1'b1;
                    case (beat.opcode)
                        lwc_pkg::ACTKEY: begin
                            state_next = KEY_INST;
                        end
                        lwc_pkg::ENC, lwc_pkg::DEC: begin
                            inst_op_next  = beat.opcode;
                            seg_kind_next = lwc_pkg::NPUB;
                            state_next    = HEADER;
                        end
                        default: begin
                            state_next = INST;
                        end
                    endcase
                end
            end
            // Key must come as an LDKEY word on SDI
            KEY_INST: begin
                if (beat_valid) begin
                    take = 1'b1;
                    if (beat.opcode == lwc_pkg::LDKEY) begin
                        seg_kind_next = lwc_pkg::KEY;
                        state_next    = HEADER;
                    end else begin
                        state_next = INST;
                    end
                end
            end
            HEADER: begin
                // Message headers also need room for the DO header
                if (beat_valid && (seg_kind != lwc_pkg::DATA || do_free)) begin
                    take         = 1'b1;
                    load         = 1'b1;
                    seg_eot_next = beat.eot;
                    do_push      = (seg_kind == lwc_pkg::DATA);
                    state_next   = HEADER_DECIDE;
                end
            end
            // Counter flags are valid here
            HEADER_DECIDE: begin
                if (is_empty) begin
                    state_next = EMPTY_BLOCK;
                end else begin
                    state_next = DATA_WORDS;
                end
            end
            DATA_WORDS: begin
                if (beat_valid && cipher_free) begin
                    take            = 1'b1;
                    step            = 1'b1;
                    cipher_push     = 1'b1;
                    cipher_cmd.last = is_last_word;
                    seg_done        = is_last_word;
                end
            end
            EMPTY_BLOCK: begin
                if (cipher_free) begin
                    cipher_push      = 1'b1;
                    cipher_cmd.last  = 1'b1;
                    cipher_cmd.empty = 1'b1;
                    cipher_cmd.data  = '0;
                    seg_done         = 1'b1;
                end
            end
            TAG_HEADER: begin
                if (do_free) begin
                    do_push        = 1'b1;
                    do_cmd.do_type = lwc_pkg::TAG_HEADER;
                    do_cmd.size    = '0;
                    state_next     = WAIT_TAG;
                end
            end
            WAIT_TAG: begin
                if (cipher_done) begin
                    state_next = STATUS;
                end
            end
            STATUS: begin
                if (do_free) begin
                    do_push     = 1'b1;
                    do_cmd.size = '0;
                    if (inst_op == lwc_pkg::ENC) begin
                        do_cmd.do_type = lwc_pkg::SUCCESS;
                    end else begin
                        do_cmd.do_type = lwc_pkg::VERIFY;
                    end
                    state_next = INST;
                end
            end
            default: begin
                state_next = INST;
            end
        endcase

        // Next segment kind once the current type ends
        if (seg_done) begin
            if (!seg_eot) begin
                state_next = HEADER;
            end else begin
                case (seg_kind)
                    lwc_pkg::KEY: begin
                        state_next = INST;
                    end
                    lwc_pkg::NPUB: begin
                        seg_kind_next = lwc_pkg::AD;
                        state_next    = HEADER;
                    end
                    lwc_pkg::AD: begin
                        seg_kind_next = lwc_pkg::DATA;
                        state_next    = HEADER;
                    end
                    lwc_pkg::DATA: begin
                        if (inst_op == lwc_pkg::ENC) begin
                            state_next = TAG_HEADER;
                        end else begin
                            seg_kind_next = lwc_pkg::TAG;
                            state_next    = HEADER;
                        end
                    end
                    default: begin
                        state_next = STATUS;
                    end
                endcase
            end
        end
    end

    // Source follows the next state so no word from the wrong bus is taken in
    always_comb begin
        case (state_next)
            INST: begin
                src_next = lwc_pkg::PDI;
            end
            KEY_INST: begin
                src_next = lwc_pkg::SDI;
            end
            HEADER, DATA_WORDS: begin
                if (seg_kind_next == lwc_pkg::KEY) begin
                    src_next = lwc_pkg::SDI;
                end else begin
                    src_next = lwc_pkg::PDI;
                end
            end
            default: begin
                src_next = lwc_pkg::NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- lwc_controller.f
hdl/lwc_pkg.sv
hdl/lwc_input_port.sv
hdl/lwc_seg_counter.sv
hdl/lwc_sequencer.sv
hdl/lwc_output_stage.sv
hdl/lwc_controller.sv
sim/tb_lwc_controller.sv

//--- sim/lwc_stimulus.txt
# P <word> / S <word>: PDI / SDI input word in hex
# C <kind> <last> <empty> <data>: expected cipher command; D <type> <size>: expected DO command
# Key activation with a 16-byte key
P 70000000
S 40000000
S C2000010
S 00112233
S 44556677
S 8899aabb
S ccddeeff
C 0 0 0 00112233
C 0 0 0 44556677
C 0 0 0 8899aabb
C 0 1 0 ccddeeff
# Encryption, 12-byte nonce, empty AD, 5-byte message
P 20000000
P D200000C
P a0a0a0a0
P a1a1a1a1
P a2a2a2a2
P 12000000
P 42000005
P b0b0b0b0
P b1000000
C 1 0 0 a0a0a0a0
C 1 0 0 a1a1a1a1
C 1 1 0 a2a2a2a2
C 2 1 1 00000000
D 2 0005
C 3 0 0 b0b0b0b0
C 3 1 0 b1000000
D 4 0000
D 5 0000
# Decryption, AD in two segments, empty ciphertext, 16-byte tag
P 30000000
P D2000004
P c0c0c0c0
P 10000006
P d0d0d0d0
P d1d10000
P 12000003
P d2d2d200
P 52000000
P 82000010
P e0e0e0e0
P e1e1e1e1
P e2e2e2e2
P e3e3e3e3
C 1 1 0 c0c0c0c0
C 2 0 0 d0d0d0d0
C 2 1 0 d1d10000
C 2 1 0 d2d2d200
D 2 0000
C 3 1 1 00000000
C 4 0 0 e0e0e0e0
C 4 0 0 e1e1e1e1
C 4 0 0 e2e2e2e2
C 4 1 0 e3e3e3e3
D 6 0000
# Unknown PDI opcode, wrong SDI opcode, then a 4-byte key
P 80000000
P 70000000
S 20000000
P 70000000
S 40000000
S C2000004
S 01020304
C 0 1 0 01020304

//--- sim/tb_lwc_controller.sv
// Run from the project root so sim/lwc_stimulus.txt is found; cipher_inst_ready is held high
`timescale 1ns/1ps
`default_nettype none

module tb_lwc_controller;

    logic                 clk;
    logic                 rst;
    lwc_pkg::word_t       pdi_data;
    logic                 pdi_valid;
    logic                 pdi_ready;
    lwc_pkg::word_t       sdi_data;
    logic                 sdi_valid;
    logic                 sdi_ready;
    logic                 cipher_inst_ready;
    logic                 cipher_done;
    lwc_pkg::cipher_cmd_t cipher_cmd_out;
    logic                 cipher_cmd_valid;
    logic                 cipher_cmd_ready;
    lwc_pkg::do_cmd_t     do_cmd_out;
    logic                 do_cmd_valid;
    logic                 do_cmd_ready;

    lwc_pkg::word_t       pdi_q[$];
    lwc_pkg::word_t       sdi_q[$];
    lwc_pkg::cipher_cmd_t exp_cipher_q[$];
    lwc_pkg::do_cmd_t     exp_do_q[$];

    integer seed;
    integer errors;
    integer checks;
    integer tag_countdown;
    logic   traffic_on;
    logic   pdi_fire;
    logic   sdi_fire;

    lwc_controller u_lwc_controller (
        .clk               (clk),
        .rst               (rst),
        .pdi_data          (pdi_data),
        .pdi_valid         (pdi_valid),
        .pdi_ready         (pdi_ready),
        .sdi_data          (sdi_data),
        .sdi_valid         (sdi_valid),
        .sdi_ready         (sdi_ready),
        .cipher_inst_ready (cipher_inst_ready),
        .cipher_done       (cipher_done),
        .cipher_cmd_out    (cipher_cmd_out),
        .cipher_cmd_valid  (cipher_cmd_valid),
        .cipher_cmd_ready  (cipher_cmd_ready),
        .do_cmd_out        (do_cmd_out),
        .do_cmd_valid      (do_cmd_valid),
        .do_cmd_ready      (do_cmd_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errors = errors + 1;
        end
    endtask

    task automatic check_outputs_low();
        check_value("pdi_ready", pdi_ready, 0);
        check_value("sdi_ready", sdi_ready, 0);
        check_value("cipher_cmd_valid", cipher_cmd_valid, 0);
        check_value("do_cmd_valid", do_cmd_valid, 0);
    endtask

    // Fills the input queues and the expected command queues
    task automatic read_stimulus();
        integer               fd;
        integer               n;
        string                line;
        logic [7:0]           tag;
        logic [31:0]          f0;
        logic [31:0]          f1;
        logic [31:0]          f2;
        logic [31:0]          f3;
        lwc_pkg::cipher_cmd_t c;
        lwc_pkg::do_cmd_t     d;
        fd = $fopen("sim/lwc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/lwc_stimulus.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h", tag, f0, f1, f2, f3);
                    case (tag)
                        "P": pdi_q.push_back(f0);
                        "S": sdi_q.push_back(f0);
                        "C": begin
                            c.kind  = lwc_pkg::seg_kind_t'(f0[2:0]);
                            c.last  = f1[0];
                            c.empty = f2[0];
                            c.data  = f3;
                            exp_cipher_q.push_back(c);
                        end
                        "D": begin
                            d.do_type = lwc_pkg::do_type_t'(f0[2:0]);
                            d.size    = f1[15:0];
                            exp_do_q.push_back(d);
                        end
                        default: begin
                            $display("Stimulus file has a line with an unknown tag: %s", line);
                            errors = errors + 1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Handshakes are sampled at the falling edge, where every signal is settled
    initial begin
        forever begin
            @(negedge clk);
            if (traffic_on) begin
                pdi_fire = pdi_valid && pdi_ready;
                sdi_fire = sdi_valid && sdi_ready;
                if (cipher_cmd_valid && cipher_cmd_ready) begin
                    if (exp_cipher_q.size() == 0) begin
                        $display("Cipher command 0x%h accepted with none expected", cipher_cmd_out);
                        errors = errors + 1;
                    end else begin
                        check_value("cipher_cmd_out", cipher_cmd_out, exp_cipher_q.pop_front());
                    end
                end
                if (do_cmd_valid && do_cmd_ready) begin
                    if (exp_do_q.size() == 0) begin
                        $display("DO command 0x%h accepted with none expected", do_cmd_out);
                        errors = errors + 1;
                    end else begin
                        check_value("do_cmd_out", do_cmd_out, exp_do_q.pop_front());
                    end
                    if (do_cmd_out.do_type == lwc_pkg::TAG_HEADER) begin
                        tag_countdown = 3;
                    end
                end
                @(posedge clk);
                #1;
                if (pdi_fire) pdi_q.delete(0);
                if (sdi_fire) sdi_q.delete(0);
                pdi_valid = 1'b0;
                sdi_valid = 1'b0;
                if (pdi_q.size() > 0) begin
                    pdi_data  = pdi_q[0];
                    pdi_valid = ({$random(seed)} % 4) != 0;
                end
                if (sdi_q.size() > 0) begin
                    sdi_data  = sdi_q[0];
                    sdi_valid = ({$random(seed)} % 4) != 0;
                end
                cipher_cmd_ready = ({$random(seed)} % 3) != 0;
                do_cmd_ready     = ({$random(seed)} % 3) != 0;
                // Cipher model finishes the tag a few cycles after the tag header
                cipher_done = 1'b0;
                if (tag_countdown > 0) begin
                    tag_countdown = tag_countdown - 1;
                    if (tag_countdown == 0) cipher_done = 1'b1;
                end
            end
        end
    end

    initial begin
        integer cycles;
        logic   finished;
        seed              = 73614;
        errors            = 0;
        checks            = 0;
        tag_countdown     = 0;
        traffic_on        = 1'b0;
        pdi_fire          = 1'b0;
        sdi_fire          = 1'b0;
        rst               = 1'b0;
        pdi_data          = '0;
        pdi_valid         = 1'b0;
        sdi_data          = '0;
        sdi_valid         = 1'b0;
        cipher_inst_ready = 1'b1;
        cipher_done       = 1'b0;
        cipher_cmd_ready  = 1'b0;
        do_cmd_ready      = 1'b0;
        read_stimulus();

        repeat (3) begin
            @(posedge clk);
            #1;
            check_outputs_low();
        end
        rst = 1'b1;
        // Values seen by the first edge after reset
        @(negedge clk);
        check_outputs_low();
        @(posedge clk);
        #1;
        traffic_on = 1'b1;

        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < 5000) begin
            @(posedge clk);
            #3;
            cycles = cycles + 1;
            finished = pdi_q.size() == 0 && sdi_q.size() == 0 && exp_cipher_q.size() == 0
                       && exp_do_q.size() == 0 && tag_countdown == 0;
        end
        if (!finished) begin
            $display("Timed out after %0d cycles with %0d cipher and %0d DO commands unseen",
                     cycles, exp_cipher_q.size(), exp_do_q.size());
            errors = errors + 1;
        end
        // Idle period to catch extra commands
        repeat (20) @(posedge clk);

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
